//--- design/app_pkg.sv
// Shared bus types, address map and register offsets for the board-control core
// Block field is address bits 15..12, register offset is bits 7..0
// Bits 31..16 and 11..8 of the address are not decoded
package app_pkg;

    // ====================
    // Bus and board types
    // ====================
    typedef logic [31:0] opb_word_t;              // One bus data word
    typedef logic [31:0] opb_addr_t;              // One bus address
    typedef logic [15:0] gpio_t;                  // Board input or output vector
    typedef logic [3:0]  led_t;                   // Bit 0 heartbeat, 3..1 status
    typedef logic [3:0]  blk_sel_t;               // Address bits 15..12

    // ====================
    // Block codes
    // ====================
    localparam blk_sel_t BLK_ID    = 4'd0;        // Version, ID, date, scratch
    localparam blk_sel_t BLK_PULSE = 4'd1;        // Tick generator
    localparam blk_sel_t BLK_GPIO  = 4'd2;        // Board I/O and LEDs

    // ====================
    // Register offsets
    // ====================
    // Identification block
    localparam logic [7:0] REG_VERSION    = 8'h00; // Firmware version, RO
    localparam logic [7:0] REG_FPGA_ID    = 8'h04; // FPGA ID, RO
    localparam logic [7:0] REG_BUILD_DATE = 8'h08; // Build date, RO
    localparam logic [7:0] REG_SCRATCH    = 8'h0C; // Scratch word, RW

    // Tick generator block
    localparam logic [7:0] REG_TICK_DIV   = 8'h00; // Cycles per tick, RW
    localparam logic [7:0] REG_SECONDS    = 8'h04; // Seconds count, RO

    // GPIO block
    localparam logic [7:0] REG_GPIO_IN    = 8'h00; // Synchronized inputs, RO
    localparam logic [7:0] REG_GPIO_OUT   = 8'h04; // Output latch, RW
    localparam logic [7:0] REG_LED        = 8'h08; // LED control, RW

    // Returned for any unmapped block or offset
    localparam opb_word_t BAD_ADDR_DATA   = 32'hDEAD_BEEF;

endpackage

//--- design/opb_decode.sv
// Block decode and registered read return for the OPB
// opb_re and opb_we must never be high in the same cycle
// opb_do holds the last read word until the next read
module opb_decode
    import app_pkg::*;
(
    input  logic      opb_clk,
    input  logic      rst_n,
    input  opb_addr_t opb_addr,
    input  logic      opb_re,
    input  logic      opb_we,
    input  opb_word_t id_rdata,               // From id_scratch_regs
    input  opb_word_t pulse_rdata,            // From pulse_gen
    input  opb_word_t gpio_rdata,             // From gpio_regs
    output logic      id_re,
    output logic      id_we,
    output logic      pulse_re,
    output logic      pulse_we,
    output logic      gpio_re,
    output logic      gpio_we,
    output opb_word_t opb_do,
    output logic      awake                   // Set by first bus access
);

    blk_sel_t  blk;                           // Block field of address
    opb_word_t rd_sel;                        // Selected read word

    // ====================
    // Block strobes
    // ====================
    assign blk      = opb_addr[15:12];
    assign id_re    = opb_re && (blk == BLK_ID);
    assign id_we    = opb_we && (blk == BLK_ID);
    assign pulse_re = opb_re && (blk == BLK_PULSE);
    assign pulse_we = opb_we && (blk == BLK_PULSE);
    assign gpio_re  = opb_re && (blk == BLK_GPIO);
    assign gpio_we  = opb_we && (blk == BLK_GPIO);

    // ====================
    // Read return
    // ====================
    always_comb begin
        if (id_re) begin
            rd_sel = id_rdata;
        end else if (pulse_re) begin
            rd_sel = pulse_rdata;
        end else if (gpio_re) begin
            rd_sel = gpio_rdata;
        end else begin
            rd_sel = BAD_ADDR_DATA;           // Dropped or unknown block
        end
    end

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            opb_do <= '0;
        end else if (opb_re) begin
            opb_do <= rd_sel;                 // Held until next read
        end
    end

    // Wake-up flag, sticky until reset
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            awake <= 1'b0;
        end else if (opb_re || opb_we) begin
            awake <= 1'b1;
        end
    end

    // Bus master never issues read and write together
    a_no_rw_overlap: assert property (
        @(posedge opb_clk) disable iff (!rst_n) !(opb_re && opb_we)
    );

endmodule

//--- design/id_scratch_regs.sv
// Build identification words and one read/write scratch register
// Writes to the version, ID and date offsets are dropped
// Read word is zero while id_re is low
module id_scratch_regs
    import app_pkg::*;
#(
    parameter opb_word_t FW_VERSION = 32'h0000_0001,
    parameter opb_word_t FPGA_ID    = 32'h0000_0100,
    parameter opb_word_t BUILD_DATE = 32'h0000_0000
) (
    input  logic      opb_clk,
    input  logic      rst_n,
    input  opb_addr_t opb_addr,
    input  opb_word_t opb_di,
    input  logic      id_re,
    input  logic      id_we,
    output opb_word_t id_rdata
);

    logic [7:0] offset;                       // Register offset
    opb_word_t  scratch_q;                    // Software scratch word
    opb_word_t  rd_word;                      // Decoded read word

    assign offset = opb_addr[7:0];

    // ====================
    // Scratch register
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch_q <= '0;
        end else if (id_we && (offset == REG_SCRATCH)) begin
            scratch_q <= opb_di;              // Only writable offset
        end
    end

    // ====================
    // Read decode
    // ====================
    always_comb begin
        case (offset)
            REG_VERSION:    rd_word = FW_VERSION;
            REG_FPGA_ID:    rd_word = FPGA_ID;
            REG_BUILD_DATE: rd_word = BUILD_DATE;
            REG_SCRATCH:    rd_word = scratch_q;
            default:        rd_word = BAD_ADDR_DATA; // Unknown offset
        endcase
    end

    assign id_rdata = id_re ? rd_word : '0;   // Quiet when not selected

endmodule

//--- design/pulse_gen.sv
// Programmable tick, 1 Hz square wave and seconds count
// Divider values below 2 run as 2; a divider write restarts the cycle count
// REG_SECONDS is read-only and wraps at 2**32
module pulse_gen
    import app_pkg::*;
#(
    parameter int unsigned TICK_DIV_INIT      = 50000, // 2 kHz at 100 MHz
    parameter int unsigned TICKS_PER_HALF_SEC = 1000   // Ticks per wave half
) (
    input  logic      opb_clk,
    input  logic      rst_n,
    input  opb_addr_t opb_addr,
    input  opb_word_t opb_di,
    input  logic      pulse_we,
    output opb_word_t pulse_rdata,
    output logic      tick_2khz,              // One cycle every N cycles
    output logic      wave_1hz
);

    logic [7:0] offset;
    logic       div_wr;                       // Divider write this cycle
    opb_word_t  div_q;                        // REG_TICK_DIV
    opb_word_t  n_eff;                        // Divider clamped to 2 or more
    opb_word_t  cyc_cnt_q;                    // Cycles since last tick
    opb_word_t  tick_cnt_q;                   // Ticks in current half wave
    opb_word_t  sec_q;                        // REG_SECONDS

    assign offset = opb_addr[7:0];
    assign div_wr = pulse_we && (offset == REG_TICK_DIV);
    assign n_eff  = (div_q < 32'd2) ? 32'd2 : div_q;

    // ====================
    // Divider and tick
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q     <= opb_word_t'(TICK_DIV_INIT);
            cyc_cnt_q <= '0;
            tick_2khz <= 1'b0;
        end else if (div_wr) begin
            div_q     <= opb_di;
            cyc_cnt_q <= '0;                  // Restart, next gap is exactly N
            tick_2khz <= 1'b0;
        end else if (cyc_cnt_q >= n_eff - 32'd1) begin
            cyc_cnt_q <= '0;                  // Also catches a shrunk divider
            tick_2khz <= 1'b1;
        end else begin
            cyc_cnt_q <= cyc_cnt_q + 32'd1;
            tick_2khz <= 1'b0;
        end
    end

    // ====================
    // Square wave and seconds
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt_q <= '0;
            wave_1hz   <= 1'b0;
            sec_q      <= '0;
        end else if (tick_2khz) begin
            if (tick_cnt_q >= opb_word_t'(TICKS_PER_HALF_SEC - 1)) begin
                tick_cnt_q <= '0;
                wave_1hz   <= ~wave_1hz;      // Half period done
                if (!wave_1hz) begin
                    sec_q <= sec_q + 32'd1;   // Rising edge of wave
                end
            end else begin
                tick_cnt_q <= tick_cnt_q + 32'd1;
            end
        end
    end

    // Read decode
    always_comb begin
        case (offset)
            REG_TICK_DIV: pulse_rdata = div_q;
            REG_SECONDS:  pulse_rdata = sec_q;
            default:      pulse_rdata = BAD_ADDR_DATA;
        endcase
    end

    // Tick stays a single-cycle pulse, also across divider writes
    a_tick_single: assert property (
        @(posedge opb_clk) disable iff (!rst_n) tick_2khz |=> !tick_2khz
    );

endmodule

//--- design/gpio_regs.sv
// Board input synchronizer, output latch and LED control
// LED outputs are active low; heartbeat follows the 1 Hz wave until awake
// heartbeat_led_n is registered and lags its source by one cycle
module gpio_regs
    import app_pkg::*;
(
    input  logic       opb_clk,
    input  logic       rst_n,
    input  opb_addr_t  opb_addr,
    input  opb_word_t  opb_di,
    input  logic       gpio_we,
    input  gpio_t      gpio_in,               // Asynchronous board inputs
    input  logic       awake,
    input  logic       wave_1hz,
    output opb_word_t  gpio_rdata,
    output gpio_t      gpio_out,
    output logic [2:0] stat_led_n,
    output logic       heartbeat_led_n
);

    logic [7:0] offset;
    gpio_t      sync1_q;                      // First synchronizer stage
    gpio_t      sync2_q;                      // Stable input sample
    gpio_t      out_q;                        // REG_GPIO_OUT
    led_t       led_q;                        // REG_LED

    assign offset = opb_addr[7:0];

    // ====================
    // Input synchronizer
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_in;
            sync2_q <= sync1_q;               // Two edges to REG_GPIO_IN
        end
    end

    // ====================
    // Output and LED latches
    // ====================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
            led_q <= '0;                      // All LEDs off
        end else if (gpio_we) begin
            if (offset == REG_GPIO_OUT) begin
                out_q <= opb_di[15:0];
            end
            if (offset == REG_LED) begin
                led_q <= opb_di[3:0];
            end
        end
    end

    // Heartbeat source picked by wake-up state
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            heartbeat_led_n <= 1'b1;          // Off in reset
        end else begin
            heartbeat_led_n <= awake ? ~led_q[0] : wave_1hz;
        end
    end

    assign gpio_out   = out_q;
    assign stat_led_n = ~led_q[3:1];          // Set bit lights LED

    // Read decode
    always_comb begin
        case (offset)
            REG_GPIO_IN:  gpio_rdata = {16'h0000, sync2_q};
            REG_GPIO_OUT: gpio_rdata = {16'h0000, out_q};
            REG_LED:      gpio_rdata = {28'h000_0000, led_q};
            default:      gpio_rdata = BAD_ADDR_DATA;
        endcase
    end

endmodule

//--- design/app_top.sv
// Register-mapped board-control core with the OPB as its port
// Blocks 0 to 2 are mapped; every other block reads 32'hDEAD_BEEF
// Tick defaults assume a 100 MHz opb_clk
module app_top
    import app_pkg::*;
#(
    parameter opb_word_t   FW_VERSION         = 32'h0000_0001,
    parameter opb_word_t   FPGA_ID            = 32'h0000_0100,
    parameter opb_word_t   BUILD_DATE         = 32'h0000_0000,
    parameter int unsigned TICK_DIV_INIT      = 50000,
    parameter int unsigned TICKS_PER_HALF_SEC = 1000
) (
    input  logic       opb_clk,
    input  logic       rst_n,
    input  opb_addr_t  opb_addr,
    input  opb_word_t  opb_di,                // Write data
    input  logic       opb_re,
    input  logic       opb_we,
    output opb_word_t  opb_do,                // Registered read data
    input  gpio_t      gpio_in,
    output gpio_t      gpio_out,
    output logic [2:0] stat_led_n,
    output logic       heartbeat_led_n,
    output logic       clkout_2khz
);

    opb_word_t id_rdata;
    opb_word_t pulse_rdata;
    opb_word_t gpio_rdata;
    logic      id_re;
    logic      id_we;
    logic      pulse_we;
    logic      gpio_we;
    logic      awake;                         // Software owns heartbeat
    logic      wave_1hz;

    // ====================
    // Decoder
    // ====================
    opb_decode u_opb_decode (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .opb_addr    (opb_addr),
        .opb_re      (opb_re),
        .opb_we      (opb_we),
        .id_rdata    (id_rdata),
        .pulse_rdata (pulse_rdata),
        .gpio_rdata  (gpio_rdata),
        .id_re       (id_re),
        .id_we       (id_we),
        .pulse_re    (),                      // Reads have no side effects
        .pulse_we    (pulse_we),
        .gpio_re     (),                      // Reads have no side effects
        .gpio_we     (gpio_we),
        .opb_do      (opb_do),
        .awake       (awake)
    );

    // ====================
    // Register blocks
    // ====================
    id_scratch_regs #(
        .FW_VERSION (FW_VERSION),
        .FPGA_ID    (FPGA_ID),
        .BUILD_DATE (BUILD_DATE)
    ) u_id_scratch_regs (
        .opb_clk  (opb_clk),
        .rst_n    (rst_n),
        .opb_addr (opb_addr),
        .opb_di   (opb_di),
        .id_re    (id_re),
        .id_we    (id_we),
        .id_rdata (id_rdata)
    );

    pulse_gen #(
        .TICK_DIV_INIT      (TICK_DIV_INIT),
        .TICKS_PER_HALF_SEC (TICKS_PER_HALF_SEC)
    ) u_pulse_gen (
        .opb_clk     (opb_clk),
        .rst_n       (rst_n),
        .opb_addr    (opb_addr),
        .opb_di      (opb_di),
        .pulse_we    (pulse_we),
        .pulse_rdata (pulse_rdata),
        .tick_2khz   (clkout_2khz),           // Straight to debug pin
        .wave_1hz    (wave_1hz)
    );

    gpio_regs u_gpio_regs (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .opb_addr        (opb_addr),
        .opb_di          (opb_di),
        .gpio_we         (gpio_we),
        .gpio_in         (gpio_in),
        .awake           (awake),
        .wave_1hz        (wave_1hz),
        .gpio_rdata      (gpio_rdata),
        .gpio_out        (gpio_out),
        .stat_led_n      (stat_led_n),
        .heartbeat_led_n (heartbeat_led_n)
    );

endmodule

//--- dv/app_top_tb.sv
// Testbench for app_top with a fast tick of 10 cycles and 4 ticks per half wave
// The heartbeat check runs first, since any bus access hands the LED to software
// Stops at the first failed check
module app_top_tb
    import app_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned TICK_DIV_TB = 10;
    localparam int unsigned HALF_SEC_TB = 4;
    localparam opb_word_t   VERSION_VAL = 32'h0003_0102;  // Firmware version word
    localparam opb_word_t   ID_VAL      = 32'h0000_0A55;  // FPGA ID word
    localparam opb_word_t   DATE_VAL    = 32'h0B1D_0007;  // Build word
    localparam int          N_ENTRIES   = 10;
    localparam int          WAIT_LIMIT  = 400;            // Cycles per wait loop

    logic       opb_clk;
    logic       rst_n;
    opb_addr_t  opb_addr;
    opb_word_t  opb_di;
    logic       opb_re;
    logic       opb_we;
    opb_word_t  opb_do;
    gpio_t      gpio_in;
    gpio_t      gpio_out;
    logic [2:0] stat_led_n;
    logic       heartbeat_led_n;
    logic       clkout_2khz;

    // Read-only entries must survive a write
    opb_addr_t  tbl_addr [N_ENTRIES];
    opb_word_t  tbl_data [N_ENTRIES];
    opb_word_t  tbl_exp  [N_ENTRIES];
    logic       tbl_ro   [N_ENTRIES];

    app_top #(
        .FW_VERSION         (VERSION_VAL),
        .FPGA_ID            (ID_VAL),
        .BUILD_DATE         (DATE_VAL),
        .TICK_DIV_INIT      (TICK_DIV_TB),
        .TICKS_PER_HALF_SEC (HALF_SEC_TB)
    ) u_app_top (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .opb_addr        (opb_addr),
        .opb_di          (opb_di),
        .opb_re          (opb_re),
        .opb_we          (opb_we),
        .opb_do          (opb_do),
        .gpio_in         (gpio_in),
        .gpio_out        (gpio_out),
        .stat_led_n      (stat_led_n),
        .heartbeat_led_n (heartbeat_led_n),
        .clkout_2khz     (clkout_2khz)
    );

    initial opb_clk = 1'b0;
    always #20 opb_clk = ~opb_clk;                        // 40 ns period

    // ====================
    // Checks
    // ====================
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string what, input opb_word_t got, input opb_word_t exp);
        if (got !== exp) begin
            report_fail($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                  $time, what, got, exp));
        end
    endtask

    task automatic check_gpio(input string what, input gpio_t got, input gpio_t exp);
        if (got !== exp) begin
            report_fail($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                  $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                  $time, what, got, exp));
        end
    endtask

    // ====================
    // Bus access
    // ====================
    function automatic opb_addr_t make_addr(input blk_sel_t blk, input logic [7:0] off);
        return {16'h0000, blk, 4'h0, off};                // Block in 15..12
    endfunction

    task automatic bus_write(input opb_addr_t addr, input opb_word_t data);
        @(posedge opb_clk);
        opb_addr <= addr;
        opb_di   <= data;
        opb_we   <= 1'b1;
        @(posedge opb_clk);                               // Write lands here
        opb_we   <= 1'b0;
    endtask

    task automatic bus_read(input opb_addr_t addr, output opb_word_t data);
        @(posedge opb_clk);
        opb_addr <= addr;
        opb_re   <= 1'b1;
        @(posedge opb_clk);                               // opb_do loads here
        opb_re   <= 1'b0;
        @(negedge opb_clk);
        data = opb_do;
    endtask

    // ====================
    // Wait loops
    // ====================
    task automatic wait_heartbeat(input logic level, input string what);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge opb_clk);
            cycles++;
            seen = (heartbeat_led_n === level);
        end
        if (!seen) begin
            report_fail($sformatf("heartbeat LED never went %b while waiting for %s",
                                  level, what));
        end
    endtask

    // Cycles counted up to and including the next tick
    task automatic wait_tick(output int cycles);
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge opb_clk);
            cycles++;
            seen = (clkout_2khz === 1'b1);
        end
        if (!seen) begin
            report_fail("no pulse seen on clkout_2khz before the timeout");
        end
    endtask

    task automatic program_tick(input opb_word_t n);
        opb_word_t exp_gap;
        opb_word_t rd;
        int        gap;
        exp_gap = (n < 32'd2) ? 32'd2 : n;                // Floor of 2 cycles
        bus_write(make_addr(BLK_PULSE, REG_TICK_DIV), n);
        bus_read(make_addr(BLK_PULSE, REG_TICK_DIV), rd);
        check_word("tick divider readback", rd, n);
        wait_tick(gap);                                   // First tick after write
        wait_tick(gap);
        check_word($sformatf("tick gap for divider %0d", n), opb_word_t'(gap), exp_gap);
    endtask

    // ====================
    // Stimulus table
    // ====================
    task automatic set_entry(input int idx, input opb_addr_t addr, input opb_word_t data,
                             input opb_word_t exp, input logic ro);
        tbl_addr[idx] = addr;
        tbl_data[idx] = data;
        tbl_exp[idx]  = ro ? exp : data;                  // RW reads back the write
        tbl_ro[idx]   = ro;
    endtask

    task automatic fill_table();
        set_entry(0, make_addr(BLK_ID, REG_VERSION), 32'hFFFF_FFFF, VERSION_VAL, 1'b1);
        set_entry(1, make_addr(BLK_ID, REG_FPGA_ID), $urandom(), ID_VAL, 1'b1);
        set_entry(2, make_addr(BLK_ID, REG_BUILD_DATE), $urandom(), DATE_VAL, 1'b1);
        set_entry(3, make_addr(BLK_ID, REG_SCRATCH), $urandom(), '0, 1'b0);
        set_entry(4, make_addr(BLK_ID, REG_SCRATCH), $urandom(), '0, 1'b0);
        set_entry(5, make_addr(BLK_ID, 8'h10), $urandom(), BAD_ADDR_DATA, 1'b1);
        set_entry(6, make_addr(4'h3, 8'h00), $urandom(), BAD_ADDR_DATA, 1'b1);
        set_entry(7, make_addr(4'hF, 8'h04), $urandom(), BAD_ADDR_DATA, 1'b1);
        set_entry(8, make_addr(BLK_PULSE, 8'h08), $urandom(), BAD_ADDR_DATA, 1'b1);
        set_entry(9, make_addr(BLK_GPIO, 8'h0C), $urandom(), BAD_ADDR_DATA, 1'b1);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        logic [31:0] rnd;
        opb_word_t   rd;
        rnd      = $urandom(32'hb762);                    // Seed once
        rst_n    <= 1'b0;
        opb_addr <= '0;
        opb_di   <= '0;
        opb_re   <= 1'b0;
        opb_we   <= 1'b0;
        gpio_in  <= '0;
        fill_table();
        repeat (16) @(posedge opb_clk);
        rst_n <= 1'b1;

        // Heartbeat follows the wave until the first bus access
        wait_heartbeat(1'b0, "reset value of the wave");
        wait_heartbeat(1'b1, "first rising edge of the wave");
        wait_heartbeat(1'b0, "end of the first full wave");
        bus_read(make_addr(BLK_PULSE, REG_SECONDS), rd);
        check_bit("seconds count nonzero", rd != 32'd0, 1'b1);

        for (int i = 0; i < N_ENTRIES; i++) begin
            if (tbl_ro[i]) begin
                bus_read(tbl_addr[i], rd);
                check_word($sformatf("entry %0d before write", i), rd, tbl_exp[i]);
                bus_write(tbl_addr[i], tbl_data[i]);
                bus_read(tbl_addr[i], rd);
                check_word($sformatf("entry %0d after write", i), rd, tbl_exp[i]);
            end else begin
                bus_write(tbl_addr[i], tbl_data[i]);
                bus_read(tbl_addr[i], rd);
                check_word($sformatf("entry %0d readback", i), rd, tbl_exp[i]);
            end
        end

        program_tick(32'd7);
        program_tick(32'd13);
        program_tick(32'd1);                              // Runs as 2

        for (int i = 0; i < 4; i++) begin
            rnd = $urandom();
            bus_write(make_addr(BLK_GPIO, REG_GPIO_OUT), rnd);
            @(negedge opb_clk);
            check_gpio("gpio_out port", gpio_out, rnd[15:0]);
            bus_read(make_addr(BLK_GPIO, REG_GPIO_OUT), rd);
            check_word("gpio_out readback", rd, {16'h0000, rnd[15:0]});
            rnd = $urandom();
            @(posedge opb_clk);
            gpio_in <= rnd[15:0];
            repeat (3) @(posedge opb_clk);                // Synchronizer settle
            bus_read(make_addr(BLK_GPIO, REG_GPIO_IN), rd);
            check_gpio("gpio_in readback", rd[15:0], rnd[15:0]);
        end

        // Software owns the LEDs now and the wave must not leak through
        for (int i = 0; i < 3; i++) begin
            rnd = $urandom();
            bus_write(make_addr(BLK_GPIO, REG_LED), {28'h000_0000, rnd[3:0]});
            repeat (2) @(negedge opb_clk);                // Heartbeat flop lag
            for (int c = 0; c < 60; c++) begin
                check_bit("heartbeat_led_n", heartbeat_led_n, ~rnd[0]);
                for (int b = 0; b < 3; b++) begin
                    check_bit($sformatf("stat_led_n[%0d]", b), stat_led_n[b], ~rnd[b + 1]);
                end
                @(negedge opb_clk);
            end
            bus_read(make_addr(BLK_GPIO, REG_LED), rd);
            check_word("LED readback", rd, {28'h000_0000, rnd[3:0]});
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- opb_app.f
design/app_pkg.sv
design/opb_decode.sv
design/id_scratch_regs.sv
design/pulse_gen.sv
design/gpio_regs.sv
design/app_top.sv
dv/app_top_tb.sv

//--- Makefile
TOP = app_top_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f opb_app.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "FAIL: see sim.log"; exit 1; \
	elif grep -q "NO ERRORS" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL: no result line in sim.log"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f opb_app.f

clean:
	rm -rf obj_dir sim.log
